//--- Makefile
# Verilator simulation of the vector processing unit

VERILATOR ?= verilator
TOP       ?= vpu_core_tb
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/obj_result_collect.sv
// Result collector
// Gathers the transformed vertices of all lanes, raises done and keeps
// a 32-entry table of the objects currently present

`timescale 1ns/1ps

module obj_result_collect (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       stall,
	input  logic [vpu_pkg::NUM_VERTS-1:0] lane_valid,
	input  vpu_pkg::vertex_t           lane_result [vpu_pkg::NUM_VERTS],
	input  vpu_pkg::vpu_op_t           op,
	input  vpu_pkg::obj_num_t          obj_num,
	output logic                       done,
	output vpu_pkg::vertex_t           vert_out [vpu_pkg::NUM_VERTS],
	output logic [31:0]                obj_present
);

	// All lanes run in lockstep, lane 0 speaks for them
	logic result_rdy;

	assign result_rdy = lane_valid[0];

	////////////////////
	// Vertex output
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= 1'b0;
			for (int i = 0; i < vpu_pkg::NUM_VERTS; i++)
				vert_out[i] <= '0;
		end else if (!stall) begin
			done <= result_rdy;
			if (result_rdy) begin
				for (int i = 0; i < vpu_pkg::NUM_VERTS; i++)
					vert_out[i] <= lane_result[i];
			end
		end
	end

	////////////////////
	// Presence table
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			obj_present <= '0;
		end else if (!stall && result_rdy) begin
			case (op)
				vpu_pkg::OP_DRAW:    obj_present[obj_num] <= 1'b1;
				vpu_pkg::OP_RMV_ONE: obj_present[obj_num] <= 1'b0;
				vpu_pkg::OP_RMV_ALL: obj_present <= '0;
				// Transforms leave the table alone
				default: ;
			endcase
		end
	end

endmodule

//--- logic/vertex_lane.sv
// Vertex transform lane
// Applies the decoded operation to one packed vertex and registers the
// result with a valid flag one cycle after lane_start

`timescale 1ns/1ps

module vertex_lane (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	input  logic                lane_start,
	input  vpu_pkg::vpu_op_t    op,
	input  vpu_pkg::vpu_code_t  code,
	input  vpu_pkg::vertex_t    vert,
	input  vpu_pkg::vertex_t    ref_pt,
	output vpu_pkg::vertex_t    result,
	output logic                valid
);

	vpu_pkg::coord_t x, y;
	vpu_pkg::coord_t cx, cy;
	vpu_pkg::coord_t dx, dy;
	vpu_pkg::coord_t rx, ry;
	vpu_pkg::coord_t nx, ny;
	vpu_pkg::coord_t step;
	logic            ccw;

	////////////////////
	// Operands
	////////////////////

	always_comb begin
		x  = vpu_pkg::coord_t'(vert[15:8]);
		y  = vpu_pkg::coord_t'(vert[7:0]);
		// Code bit 3 picks the reference point as centre
		cx = code[3] ? vpu_pkg::coord_t'(ref_pt[15:8]) : '0;
		cy = code[3] ? vpu_pkg::coord_t'(ref_pt[7:0]) : '0;
		dx = x - cx;
		dy = y - cy;
		step = {6'd0, code[3:2]} + 8'd1;
		ccw  = (op == vpu_pkg::OP_ROT_CCW);
	end

	// Quarter turns about the centre, offsets only
	always_comb begin
		case (code[1:0])
			2'd1: begin
				rx = ccw ? -dy : dy;
				ry = ccw ? dx : -dx;
			end
			2'd2: begin
				rx = -dx;
				ry = -dy;
			end
			2'd3: begin
				rx = ccw ? dy : -dy;
				ry = ccw ? -dx : dx;
			end
			default: begin
				rx = dx;
				ry = dy;
			end
		endcase
	end

	////////////////////
	// Operation select
	////////////////////

	always_comb begin
		nx = x;
		ny = y;
		case (op)
			vpu_pkg::OP_TRAN_POS: begin
				if (code[1]) nx = x + step;
				if (code[0]) ny = y + step;
			end
			vpu_pkg::OP_TRAN_NEG: begin
				if (code[1]) nx = x - step;
				if (code[0]) ny = y - step;
			end
			vpu_pkg::OP_ROT_CCW, vpu_pkg::OP_ROT_CW: begin
				nx = rx + cx;
				ny = ry + cy;
			end
			vpu_pkg::OP_SCALE: begin
				nx = (dx <<< code[2:0]) + cx;
				ny = (dy <<< code[2:0]) + cy;
			end
			vpu_pkg::OP_REFL_X:  nx = -x;
			vpu_pkg::OP_REFL_Y:  ny = -y;
			vpu_pkg::OP_REFL_XY: begin
				nx = -x;
				ny = -y;
			end
			// Draw, remove, matrix and get-object pass through
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
			valid  <= 1'b0;
		end else if (!stall) begin
			valid <= lane_start;
			if (lane_start)
				result <= {nx, ny};
		end
	end

endmodule

//--- logic/vpu_core.sv
// Vector processing unit top level
// Decode register, eight vertex transform lanes and the result
// collector, three register stages from start to done

`timescale 1ns/1ps

module vpu_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	input  logic                start,
	input  vpu_pkg::instr_t     instr,
	input  vpu_pkg::vertex_t    vert_in [vpu_pkg::NUM_VERTS],
	input  vpu_pkg::vertex_t    ref_pt,
	output logic                fill,
	output vpu_pkg::color_t     obj_color,
	output vpu_pkg::obj_type_t  obj_type,
	output logic                done,
	output vpu_pkg::vertex_t    vert_out [vpu_pkg::NUM_VERTS],
	output logic [31:0]         obj_present
);

	logic                          lane_start;
	vpu_pkg::vpu_op_t              op;
	vpu_pkg::vpu_code_t            code;
	vpu_pkg::obj_num_t             obj_num;
	vpu_pkg::vertex_t              dec_vert [vpu_pkg::NUM_VERTS];
	vpu_pkg::vertex_t              ref_q;
	vpu_pkg::vertex_t              lane_result [vpu_pkg::NUM_VERTS];
	logic [vpu_pkg::NUM_VERTS-1:0] lane_valid;

	// Object fields delayed to line up with the lane outputs
	vpu_pkg::vpu_op_t              op_q;
	vpu_pkg::obj_num_t             obj_num_q;

	vpu_decode_reg decode_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.start      (start),
		.instr      (instr),
		.vert_in    (vert_in),
		.ref_pt     (ref_pt),
		.lane_start (lane_start),
		.fill       (fill),
		.op         (op),
		.code       (code),
		.obj_type   (obj_type),
		.obj_color  (obj_color),
		.obj_num    (obj_num),
		.vert_out   (dec_vert),
		.ref_out    (ref_q)
	);

	////////////////////
	// Vertex lanes
	////////////////////

	for (genvar i = 0; i < vpu_pkg::NUM_VERTS; i++) begin : g_lane
		vertex_lane lane_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.stall      (stall),
			.lane_start (lane_start),
			.op         (op),
			.code       (code),
			.vert       (dec_vert[i]),
			.ref_pt     (ref_q),
			.result     (lane_result[i]),
			.valid      (lane_valid[i])
		);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op_q      <= vpu_pkg::OP_DRAW;
			obj_num_q <= '0;
		end else if (!stall) begin
			op_q      <= op;
			obj_num_q <= obj_num;
		end
	end

	obj_result_collect collect_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.lane_valid  (lane_valid),
		.lane_result (lane_result),
		.op          (op_q),
		.obj_num     (obj_num_q),
		.done        (done),
		.vert_out    (vert_out),
		.obj_present (obj_present)
	);

endmodule

//--- logic/vpu_decode_reg.sv
// VPU decode register
// Turns the 16-bit drawing instruction into an operation, a code field
// and object fields, and registers them together with the vertices and
// the reference point. A stall holds every register.

`timescale 1ns/1ps

module vpu_decode_reg (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	input  logic                start,
	input  vpu_pkg::instr_t     instr,
	input  vpu_pkg::vertex_t    vert_in [vpu_pkg::NUM_VERTS],
	input  vpu_pkg::vertex_t    ref_pt,
	output logic                lane_start,
	output logic                fill,
	output vpu_pkg::vpu_op_t    op,
	output vpu_pkg::vpu_code_t  code,
	output vpu_pkg::obj_type_t  obj_type,
	output vpu_pkg::color_t     obj_color,
	output vpu_pkg::obj_num_t   obj_num,
	output vpu_pkg::vertex_t    vert_out [vpu_pkg::NUM_VERTS],
	output vpu_pkg::vertex_t    ref_out
);

	vpu_pkg::vpu_op_t   dec_op;
	vpu_pkg::vpu_code_t dec_code;
	logic               dec_fill;

	////////////////////
	// Opcode decode
	////////////////////

	always_comb begin
		dec_fill = 1'b0;
		dec_op   = vpu_pkg::OP_DRAW;
		// Translate layout: step in bits 3:2, x/y enables in bits 1:0
		dec_code = {instr[1:0], instr[3:2]};

		case (instr[15:11])
			vpu_pkg::OPC_FILL: begin
				dec_fill = 1'b1;
			end
			vpu_pkg::OPC_RMV: begin
				dec_op = instr[10] ? vpu_pkg::OP_RMV_ALL : vpu_pkg::OP_RMV_ONE;
			end
			vpu_pkg::OPC_TRAN: begin
				dec_op = instr[10] ? vpu_pkg::OP_TRAN_NEG : vpu_pkg::OP_TRAN_POS;
			end
			vpu_pkg::OPC_ROT: begin
				dec_op   = instr[10] ? vpu_pkg::OP_ROT_CCW : vpu_pkg::OP_ROT_CW;
				// Centre select in bit 3, amount below
				dec_code = instr[3:0];
			end
			vpu_pkg::OPC_SCALE: begin
				dec_op   = vpu_pkg::OP_SCALE;
				dec_code = instr[3:0];
			end
			vpu_pkg::OPC_REFLECT: begin
				case (instr[1:0])
					2'd1:    dec_op = vpu_pkg::OP_REFL_X;
					2'd2:    dec_op = vpu_pkg::OP_REFL_Y;
					default: dec_op = vpu_pkg::OP_REFL_XY;
				endcase
			end
			vpu_pkg::OPC_MAT: begin
				dec_op = instr[10] ? vpu_pkg::OP_MAT_APPLY : vpu_pkg::OP_MAT_LOAD;
			end
			vpu_pkg::OPC_GETOBJ: begin
				dec_op = vpu_pkg::OP_GETOBJ;
			end
			// Draw, ellipse and unknown codes all draw
			default: begin
				dec_op = vpu_pkg::OP_DRAW;
			end
		endcase
	end

	////////////////////
	// Pipeline register
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lane_start <= 1'b0;
			fill       <= 1'b0;
			op         <= vpu_pkg::OP_DRAW;
			code       <= '0;
			obj_type   <= '0;
			obj_color  <= '0;
			obj_num    <= '0;
			ref_out    <= '0;
			for (int i = 0; i < vpu_pkg::NUM_VERTS; i++)
				vert_out[i] <= '0;
		end else if (!stall) begin
			// Fill goes out on its own strobe, lanes stay idle
			lane_start <= start & ~dec_fill;
			fill       <= start & dec_fill;
			op         <= dec_op;
			code       <= dec_code;
			obj_type   <= instr[10:9];
			obj_color  <= instr[2:0];
			obj_num    <= instr[9:5];
			ref_out    <= ref_pt;
			for (int i = 0; i < vpu_pkg::NUM_VERTS; i++)
				vert_out[i] <= vert_in[i];
		end
	end

endmodule

//--- logic/vpu_pkg.sv
// Vector processing unit shared definitions
// Opcodes of the drawing instruction set, the decoded operation
// encoding and the widths of vertices, coordinates and object fields

package vpu_pkg;

	////////////////////
	// Sizes
	////////////////////

	// One transform lane per vertex
	localparam int NUM_VERTS = 8;

	////////////////////
	// Opcodes
	////////////////////

	// Found in instruction bits 15:11
	localparam logic [4:0] OPC_DRAW    = 5'b10000;
	// Ellipse decodes as draw
	localparam logic [4:0] OPC_ELLI    = 5'b10001;
	localparam logic [4:0] OPC_FILL    = 5'b10010;
	localparam logic [4:0] OPC_RMV     = 5'b10011;
	localparam logic [4:0] OPC_TRAN    = 5'b10100;
	localparam logic [4:0] OPC_ROT     = 5'b10101;
	localparam logic [4:0] OPC_SCALE   = 5'b10110;
	localparam logic [4:0] OPC_REFLECT = 5'b10111;
	localparam logic [4:0] OPC_MAT     = 5'b11000;
	localparam logic [4:0] OPC_GETOBJ  = 5'b11001;

	////////////////////
	// Data types
	////////////////////

	typedef logic [15:0] instr_t;

	// x in the upper byte, y in the lower byte
	typedef logic [15:0] vertex_t;

	typedef logic signed [7:0] coord_t;

	// Operation specific modifier bits
	typedef logic [3:0] vpu_code_t;

	typedef logic [4:0] obj_num_t;
	typedef logic [1:0] obj_type_t;
	typedef logic [2:0] color_t;

	// Decoded operation seen by the lanes and the collector
	typedef enum logic [3:0] {
		OP_DRAW      = 4'h0,
		OP_RMV_ONE   = 4'h1,
		OP_RMV_ALL   = 4'h2,
		OP_TRAN_POS  = 4'h3,
		OP_TRAN_NEG  = 4'h4,
		OP_SCALE     = 4'h5,
		OP_ROT_CCW   = 4'h6,
		OP_ROT_CW    = 4'h7,
		OP_REFL_X    = 4'h8,
		OP_REFL_Y    = 4'h9,
		OP_REFL_XY   = 4'hA,
		OP_MAT_LOAD  = 4'hB,
		OP_MAT_APPLY = 4'hC,
		OP_GETOBJ    = 4'hF
	} vpu_op_t;

endpackage

//--- tb.f
logic/vpu_pkg.sv
logic/vpu_decode_reg.sv
logic/vertex_lane.sv
logic/obj_result_collect.sv
logic/vpu_core.sv
testbench/vpu_core_sva.sv
testbench/vpu_core_tb.sv

//--- testbench/vpu_core_sva.sv
// VPU timing assertions
// Start to done latency, fill handling, stall hold and lane lockstep

`timescale 1ns/1ps

module vpu_core_sva (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          stall,
	input logic                          start,
	input vpu_pkg::instr_t               instr,
	input logic                          fill,
	input logic                          done,
	input vpu_pkg::vertex_t              vert_out [vpu_pkg::NUM_VERTS],
	input logic [31:0]                   obj_present,
	input logic [vpu_pkg::NUM_VERTS-1:0] lane_valid
);

	logic [16*vpu_pkg::NUM_VERTS-1:0] vert_flat;
	logic                             acc_fill;
	logic                             acc_op;

	// Number of assertion failures so far
	int                               fail_count = 0;

	for (genvar i = 0; i < vpu_pkg::NUM_VERTS; i++) begin : g_flat
		assign vert_flat[16*i +: 16] = vert_out[i];
	end

	// Start taken on this edge
	assign acc_fill = start && !stall && (instr[15:11] == vpu_pkg::OPC_FILL);
	assign acc_op   = start && !stall && (instr[15:11] != vpu_pkg::OPC_FILL);

	a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$past(acc_op, 3) && !$past(stall, 2) && !$past(stall, 1) |-> done)
		else begin
			fail_count++;
			$error("done missing three cycles after start");
		end

	a_fill_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		acc_fill |=> fill)
		else begin
			fail_count++;
			$error("fill missing one cycle after fill instruction");
		end

	a_fill_no_done: assert property (@(posedge clk) disable iff (!rst_n)
		$past(acc_fill, 3) && !$past(stall, 2) && !$past(stall, 1) |-> !done)
		else begin
			fail_count++;
			$error("done raised for a fill instruction");
		end

	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(done) && $stable(fill) && $stable(vert_flat) && $stable(obj_present))
		else begin
			fail_count++;
			$error("outputs changed during stall");
		end

	a_lane_lockstep: assert property (@(posedge clk) disable iff (!rst_n)
		(lane_valid == '0) || (lane_valid == '1))
		else begin
			fail_count++;
			$error("lane valid bits differ");
		end

endmodule

bind vpu_core vpu_core_sva sva_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.stall       (stall),
	.start       (start),
	.instr       (instr),
	.fill        (fill),
	.done        (done),
	.vert_out    (vert_out),
	.obj_present (obj_present),
	.lane_valid  (lane_valid)
);

//--- testbench/vpu_core_tb.sv
// VPU testbench
// Drives random and directed drawing instructions into the vector
// processing unit and checks vertices, presence table, fill and latency
// against a reference model

`timescale 1ns/1ps

module vpu_core_tb;

	localparam int VW          = 16 * vpu_pkg::NUM_VERTS;
	localparam int N_RAND      = 64;
	localparam int N_FILL      = 3;
	localparam int N_PRES      = 12;
	localparam int N_B2B       = 8;
	localparam int N_STALL     = 5;
	localparam int STALL_LEN   = 6;
	localparam int STALL_CYC   = STALL_LEN + 2;
	localparam int N_INSTR     = N_RAND + N_FILL + N_PRES + N_B2B + N_STALL;
	localparam int TIMEOUT_CYC = N_INSTR * 3 + STALL_CYC + 50;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               stall;
	logic               start;
	vpu_pkg::instr_t    instr;
	vpu_pkg::vertex_t   vert_in [vpu_pkg::NUM_VERTS];
	vpu_pkg::vertex_t   ref_pt;
	logic               fill;
	vpu_pkg::color_t    obj_color;
	vpu_pkg::obj_type_t obj_type;
	logic               done;
	vpu_pkg::vertex_t   vert_out [vpu_pkg::NUM_VERTS];
	logic [31:0]        obj_present;

	logic [31:0]   seed = 32'd5071;
	logic [31:0]   model_present = '0;
	logic [VW-1:0] exp_vert_q [$];
	logic [31:0]   exp_pres_q [$];
	int            exp_adv_q [$];
	logic [4:0]    fill_q [$];
	int            fill_adv_q [$];
	logic [VW-1:0] ev;
	logic [31:0]   ep;
	logic [4:0]    ef;
	int            ea;
	int            adv_edges = 0;
	int            cyc = 0;
	int            checks = 0;
	int            errors = 0;

	vpu_core vpu_core_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.start       (start),
		.instr       (instr),
		.vert_in     (vert_in),
		.ref_pt      (ref_pt),
		.fill        (fill),
		.obj_color   (obj_color),
		.obj_type    (obj_type),
		.done        (done),
		.vert_out    (vert_out),
		.obj_present (obj_present)
	);

	always #10 clk = ~clk;

	// Pipeline advances only on edges without stall
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (rst_n && !stall)
			adv_edges <= adv_edges + 1;
		if (cyc >= TIMEOUT_CYC) begin
			$display("Error: run did not finish within %0d cycles", TIMEOUT_CYC);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic vpu_pkg::instr_t rand_xform();
		logic [31:0] r;
		logic [4:0]  opc;
		r = next_rand();
		case (r[29:28])
			2'd0:    opc = vpu_pkg::OPC_TRAN;
			2'd1:    opc = vpu_pkg::OPC_ROT;
			2'd2:    opc = vpu_pkg::OPC_SCALE;
			default: opc = vpu_pkg::OPC_REFLECT;
		endcase
		return {opc, r[26:16]};
	endfunction

	function automatic vpu_pkg::instr_t rand_any();
		logic [31:0] r;
		logic [4:0]  opc;
		r = next_rand();
		// Opcodes are 16 to 25
		opc = 5'd16 + 5'(int'(r[30:27]) % 10);
		return {opc, r[26:16]};
	endfunction

	function automatic vpu_pkg::instr_t obj_instr(input logic [4:0] opc, input logic b10,
			input vpu_pkg::obj_num_t num);
		return {opc, b10, num, 5'd0};
	endfunction

	// Expected vertices of one instruction with the presence table updated in place
	function automatic logic [VW-1:0] ref_vpu(input vpu_pkg::instr_t ins,
			input logic [VW-1:0] vin, input vpu_pkg::vertex_t rp, inout logic [31:0] pres);
		logic [VW-1:0] vout;
		int x, y, cx, cy, t, step;
		vout = vin;
		cx = 0;
		cy = 0;
		if (ins[3]) begin
			cx = int'(vpu_pkg::coord_t'(rp[15:8]));
			cy = int'(vpu_pkg::coord_t'(rp[7:0]));
		end
		for (int i = 0; i < vpu_pkg::NUM_VERTS; i++) begin
			x = int'(vpu_pkg::coord_t'(vin[16*i+8 +: 8]));
			y = int'(vpu_pkg::coord_t'(vin[16*i +: 8]));
			case (ins[15:11])
				vpu_pkg::OPC_TRAN: begin
					// Step in bits 1:0 with the x and y enables in bits 3 and 2
					step = int'(ins[1:0]) + 1;
					if (ins[10])
						step = -step;
					if (ins[3])
						x = x + step;
					if (ins[2])
						y = y + step;
				end
				vpu_pkg::OPC_ROT: begin
					x = x - cx;
					y = y - cy;
					for (int k = 0; k < int'(ins[1:0]); k++) begin
						t = x;
						if (ins[10]) begin
							x = -y;
							y = t;
						end else begin
							x = y;
							y = -t;
						end
					end
					x = x + cx;
					y = y + cy;
				end
				vpu_pkg::OPC_SCALE: begin
					x = ((x - cx) << ins[2:0]) + cx;
					y = ((y - cy) << ins[2:0]) + cy;
				end
				vpu_pkg::OPC_REFLECT: begin
					if (ins[1:0] != 2'd2)
						x = -x;
					if (ins[1:0] != 2'd1)
						y = -y;
				end
				default: ;
			endcase
			vout[16*i +: 16] = {x[7:0], y[7:0]};
		end
		case (ins[15:11])
			vpu_pkg::OPC_RMV: begin
				if (ins[10])
					pres = '0;
				else
					pres[ins[9:5]] = 1'b0;
			end
			vpu_pkg::OPC_TRAN, vpu_pkg::OPC_ROT, vpu_pkg::OPC_SCALE, vpu_pkg::OPC_REFLECT,
			vpu_pkg::OPC_MAT, vpu_pkg::OPC_GETOBJ, vpu_pkg::OPC_FILL: ;
			// Draw, ellipse and unknown codes mark the object
			default: pres[ins[9:5]] = 1'b1;
		endcase
		return vout;
	endfunction

	task automatic send(input vpu_pkg::instr_t ins);
		logic [VW-1:0]    vflat;
		logic [31:0]      r;
		vpu_pkg::vertex_t rp;
		@(posedge clk);
		#2;
		for (int i = 0; i < vpu_pkg::NUM_VERTS; i++) begin
			r = next_rand();
			vert_in[i] = r[23:8];
			vflat[16*i +: 16] = r[23:8];
		end
		r = next_rand();
		rp = r[23:8];
		ref_pt = rp;
		instr = ins;
		start = 1'b1;
		stall = 1'b0;
		if (ins[15:11] == vpu_pkg::OPC_FILL) begin
			fill_q.push_back({ins[10:9], ins[2:0]});
			fill_adv_q.push_back(adv_edges);
		end else begin
			exp_vert_q.push_back(ref_vpu(ins, vflat, rp, model_present));
			exp_pres_q.push_back(model_present);
			exp_adv_q.push_back(adv_edges);
		end
	endtask

	// A draw offered during the stall must be dropped
	task automatic hold_stall(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#2;
			r = next_rand();
			stall = 1'b1;
			start = 1'b1;
			instr = {vpu_pkg::OPC_DRAW, r[26:16]};
		end
	endtask

	task automatic drain();
		int n;
		@(posedge clk);
		#2;
		start = 1'b0;
		stall = 1'b0;
		n = 0;
		while ((exp_vert_q.size() != 0 || fill_q.size() != 0) && n < 20) begin
			@(posedge clk);
			n++;
		end
		checks++;
		assert (n < 20) else begin
			errors++;
			$display("Error at %0t: results still missing after %0d cycles", $time, n);
			exp_vert_q.delete();
			exp_pres_q.delete();
			exp_adv_q.delete();
			fill_q.delete();
			fill_adv_q.delete();
		end
	endtask

	task automatic check_reset();
		checks++;
		assert (done == 1'b0) else begin
			errors++;
			$display("Fail at %0t: done expected 0 got %b", $time, done);
		end
		assert (fill == 1'b0) else begin
			errors++;
			$display("Fail at %0t: fill expected 0 got %b", $time, fill);
		end
		assert (obj_color == '0) else begin
			errors++;
			$display("Fail at %0t: obj_color expected 0 got %b", $time, obj_color);
		end
		assert (obj_type == '0) else begin
			errors++;
			$display("Fail at %0t: obj_type expected 0 got %b", $time, obj_type);
		end
		assert (obj_present == '0) else begin
			errors++;
			$display("Fail at %0t: obj_present expected 0 got %h", $time, obj_present);
		end
		for (int i = 0; i < vpu_pkg::NUM_VERTS; i++) begin
			assert (vert_out[i] == '0) else begin
				errors++;
				$display("Fail at %0t: vert_out[%0d] expected 0 got %h", $time, i, vert_out[i]);
			end
		end
	endtask

	////////////////////
	// Result compare
	////////////////////

	// A result counts once on the cycle it is not held by stall
	always @(negedge clk) begin
		if (rst_n && done && !stall) begin
			checks++;
			assert (exp_vert_q.size() != 0) else begin
				errors++;
				$display("Error at %0t: done raised with no instruction pending", $time);
			end
			if (exp_vert_q.size() != 0) begin
				ev = exp_vert_q.pop_front();
				ep = exp_pres_q.pop_front();
				ea = exp_adv_q.pop_front();
				for (int i = 0; i < vpu_pkg::NUM_VERTS; i++) begin
					assert (vert_out[i] == ev[16*i +: 16]) else begin
						errors++;
						$display("Fail at %0t: vert_out[%0d] expected %h got %h",
							$time, i, ev[16*i +: 16], vert_out[i]);
					end
				end
				assert (obj_present == ep) else begin
					errors++;
					$display("Fail at %0t: obj_present expected %h got %h", $time, ep, obj_present);
				end
				assert (adv_edges - ea == 3) else begin
					errors++;
					$display("Fail at %0t: done latency expected 3 got %0d", $time, adv_edges - ea);
				end
			end
		end
		if (rst_n && fill && !stall) begin
			checks++;
			assert (fill_q.size() != 0) else begin
				errors++;
				$display("Error at %0t: fill raised with no fill instruction pending", $time);
			end
			if (fill_q.size() != 0) begin
				ef = fill_q.pop_front();
				ea = fill_adv_q.pop_front();
				assert ({obj_type, obj_color} == ef) else begin
					errors++;
					$display("Fail at %0t: obj_type/obj_color expected %b got %b",
						$time, ef, {obj_type, obj_color});
				end
				assert (adv_edges - ea == 1) else begin
					errors++;
					$display("Fail at %0t: fill latency expected 1 got %0d", $time, adv_edges - ea);
				end
			end
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		rst_n = 1'b0;
		stall = 1'b0;
		start = 1'b0;
		instr = '0;
		ref_pt = '0;
		for (int i = 0; i < vpu_pkg::NUM_VERTS; i++)
			vert_in[i] = '0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_reset();

		// Random transforms back to back
		for (int n = 0; n < N_RAND; n++)
			send(rand_xform());
		drain();

		// Fill strobes with a transform in between
		send({vpu_pkg::OPC_FILL, 2'b01, 6'd0, 3'd5});
		send(rand_xform());
		send({vpu_pkg::OPC_FILL, 2'b10, 6'd0, 3'd3});
		drain();

		// Presence table
		send(obj_instr(vpu_pkg::OPC_DRAW, 1'b0, 5'd3));
		send(obj_instr(vpu_pkg::OPC_DRAW, 1'b0, 5'd17));
		send(obj_instr(vpu_pkg::OPC_ELLI, 1'b0, 5'd30));
		send(obj_instr(vpu_pkg::OPC_DRAW, 1'b0, 5'd0));
		send(obj_instr(vpu_pkg::OPC_RMV, 1'b0, 5'd17));
		send(obj_instr(vpu_pkg::OPC_MAT, 1'b0, 5'd4));
		send(obj_instr(vpu_pkg::OPC_MAT, 1'b1, 5'd4));
		send(obj_instr(vpu_pkg::OPC_GETOBJ, 1'b0, 5'd3));
		send(obj_instr(vpu_pkg::OPC_RMV, 1'b1, 5'd0));
		send(obj_instr(vpu_pkg::OPC_DRAW, 1'b0, 5'd9));
		send(obj_instr(vpu_pkg::OPC_DRAW, 1'b0, 5'd31));
		send(obj_instr(vpu_pkg::OPC_RMV, 1'b0, 5'd9));
		drain();

		// Mixed opcodes back to back
		for (int n = 0; n < N_B2B; n++)
			send(rand_any());
		drain();

		// Stall with work in flight and then a short one near done
		for (int n = 0; n < 3; n++)
			send(rand_xform());
		hold_stall(STALL_LEN);
		send(rand_xform());
		send(rand_xform());
		hold_stall(STALL_CYC - STALL_LEN);
		drain();

		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			vpu_core_i.sva_i.fail_count);
		if (errors == 0 && vpu_core_i.sva_i.fail_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
